//--- all.f
src/rv32i_pkg.sv
src/cpu_pkg.sv
src/pipe_if.sv
src/cpu_status.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/ma_stage.sv
src/forwarding.sv
src/cpu_top.sv
bench/tb_cpu_top.sv

//--- bench/tb_cpu_top.sv
/*
 * testbench for the rv32i core
 * runs directed and random programs and checks data ram against a model
 */
module tb_cpu_top import rv32i_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk = 1'b0;
	logic i_arst_n, i_cpu_start, i_quit_cmd, i_iram_we, o_cpu_run_state;
	logic [29:0] i_start_adr;
	logic [9:0] i_iram_wadr, i_dram_radr;
	logic [31:0] i_iram_wdata, o_dram_rdata, o_pc_data;

	logic [31:0] prog [$];
	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic touched [1024];
	logic [31:0] regs [32];
	logic [31:0] rng = 32'd65990;
	int errors = 0;
	int budget = 0;
	int run_cycles = 0;
	logic check_req = 1'b0;

	cpu_top i_cpu_top (.clk(clk), .i_arst_n(i_arst_n), .i_cpu_start(i_cpu_start),
		.i_quit_cmd(i_quit_cmd), .i_start_adr(i_start_adr), .i_iram_we(i_iram_we),
		.i_iram_wadr(i_iram_wadr), .i_iram_wdata(i_iram_wdata), .i_dram_radr(i_dram_radr),
		.o_cpu_run_state(o_cpu_run_state), .o_dram_rdata(o_dram_rdata),
		.o_pc_data(o_pc_data));

	always #50 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// instruction-set reference that runs until ecall
	function automatic int run_model(input int start_word);
		logic [31:0] pc, npc, w, a, b, res, imm_i;
		logic [2:0] f3;
		logic wr, halted;
		int steps;
		pc = start_word * 4;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < 5000) begin
			w = imem[pc[11:2]];
			f3 = w[14:12];
			a = (w[19:15] == 0) ? 0 : regs[w[19:15]];
			b = (w[24:20] == 0) ? 0 : regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			npc = pc + 4;
			wr = 1'b1;
			res = 0;
			steps++;
			case (w[6:0])
				OPC_OP: res = alu(f3, w[30], a, b);
				OPC_OP_IMM: res = alu(f3, f3 == 3'd5 && w[30], a, imm_i);
				OPC_LUI: res = {w[31:12], 12'b0};
				OPC_AUIPC: res = pc + {w[31:12], 12'b0};
				OPC_LOAD: begin
					wr = (f3 == F3_WORD);
					res = dmem[(a + imm_i) >> 2 & 1023];
				end
				OPC_STORE: begin
					wr = 1'b0;
					if (f3 == F3_WORD) begin
						dmem[(a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2 & 1023] = b;
						touched[(a + {{20{w[31]}}, w[31:25], w[11:7]}) >> 2 & 1023] = 1'b1;
					end
				end
				OPC_BRANCH: begin
					wr = 1'b0;
					if (taken(f3, a, b))
						npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
				OPC_JAL: begin
					res = pc + 4;
					npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				end
				OPC_JALR: begin
					res = pc + 4;
					npc = (a + imm_i) & ~32'd3;
				end
				default: begin
					wr = 1'b0;
					halted = (w == 32'h0000_0073); // ecall
				end
			endcase
			if (wr && w[11:7] != 0)
				regs[w[11:7]] = res;
			pc = npc;
		end
		if (!halted) begin
			$display("model did not reach ecall at time %0t", $time);
			errors++;
		end
		return steps;
	endfunction

	// reads back each touched word through the host port
	initial begin
		logic [31:0] exp;
		forever begin
			wait (check_req);
			for (int i = 0; i < 1024; i++) begin
				if (touched[i]) begin
					@(posedge clk) i_dram_radr <= 10'(i);
					@(posedge clk);
					@(negedge clk);
					exp = dmem[i];
					if (o_dram_rdata !== exp) begin
						$display("error %0t: addr %h expected %h actual %h", $time, i * 4,
							exp, o_dram_rdata);
						errors++;
					end
				end
			end
			check_req = 1'b0;
		end
	end

	// cycle budget grows by (steps*4 + 50) per run
	always @(negedge clk) begin
		if (o_cpu_run_state) begin
			run_cycles++;
			if (run_cycles > budget) begin
				$display("core hung: run went past its cycle budget at %0t", $time);
				$display("Test failed");
				$finish;
			end
		end
	end

	task automatic emit(input logic [31:0] w);
		prog.push_back(w);
	endtask

	task automatic prologue();
		for (int k = 1; k < 32; k++)
			emit(enc_i(12'd0, 5'd0, F3_ADD, 5'(k), OPC_OP_IMM));
		for (int k = 0; k < 16; k++)
			emit(enc_s(12'(k * 4), 5'd0, 5'd0)); // zero the data image
	endtask

	task automatic load_prog(input int base);
		foreach (prog[k]) begin
			@(posedge clk);
			i_iram_we <= 1'b1;
			i_iram_wadr <= 10'(base + k);
			i_iram_wdata <= prog[k];
			imem[base + k] = prog[k];
		end
		@(posedge clk) i_iram_we <= 1'b0;
	endtask

	task automatic start_core(input int base, output logic ok);
		logic [31:0] exp_pc;
		@(posedge clk);
		i_start_adr <= 30'(base);
		i_cpu_start <= 1'b1;
		@(posedge clk) i_cpu_start <= 1'b0;
		@(negedge clk);
		ok = o_cpu_run_state;
		if (!ok) begin
			$display("core did not enter the run state at %0t", $time);
			errors++;
		end else begin
			repeat (2) @(negedge clk); // fetch and decode before ex
			exp_pc = base * 4;
			if (o_pc_data !== exp_pc) begin
				$display("error %0t: start pc expected %h actual %h", $time, exp_pc,
					o_pc_data);
				errors++;
			end
		end
	endtask

	task automatic run_test(input int base);
		int steps;
		logic ok;
		load_prog(base);
		foreach (touched[k])
			touched[k] = 1'b0;
		steps = run_model(base);
		budget += steps * 4 + 50;
		start_core(base, ok);
		while (ok && o_cpu_run_state)
			@(negedge clk);
		check_req = 1'b1;
		wait (!check_req);
		prog.delete();
	endtask

	task automatic random_prog();
		logic [31:0] r;
		logic [2:0] f3;
		logic alt;
		prologue();
		repeat (40) begin
			r = next_rand();
			f3 = r[10:8];
			alt = r[11] && (f3 == 3'd0 || f3 == 3'd5);
			case (r % 7)
				0, 1: emit(enc_r({1'b0, alt, 5'd0}, r[14:12], r[17:15], f3, r[20:18]));
				2: begin
					if (f3 == 3'd1)
						emit(enc_i({7'd0, r[25:21]}, r[17:15], f3, r[20:18], OPC_OP_IMM));
					else if (f3 == 3'd5)
						emit(enc_i({1'b0, r[11], 5'd0, r[25:21]}, r[17:15], f3, r[20:18],
							OPC_OP_IMM));
					else
						emit(enc_i(r[31:20], r[17:15], f3, r[20:18], OPC_OP_IMM));
				end
				3: emit({r[31:12], 2'b0, r[4:2], OPC_LUI});
				4: emit({r[31:12], 2'b0, r[4:2], OPC_AUIPC});
				5: emit(enc_i({6'd0, r[27:24], 2'b0}, 5'd0, F3_WORD, r[20:18], OPC_LOAD));
				default: emit(enc_s({6'd0, r[27:24], 2'b0}, r[14:12], 5'd0));
			endcase
		end
		emit(32'h0000_0073);
	endtask

	initial begin
		logic ok;
		i_arst_n = 1'b0;
		i_cpu_start = 1'b0;
		i_quit_cmd = 1'b0;
		i_start_adr = '0;
		i_iram_we = 1'b0;
		i_iram_wadr = '0;
		i_iram_wdata = '0;
		i_dram_radr = '0;
		foreach (imem[k])
			imem[k] = 32'h0;
		foreach (regs[k])
			regs[k] = 32'h0;
		repeat (3) @(posedge clk);
		i_arst_n <= 1'b1;

		// dependent alu chain with forwarding from ex, ma and write-back
		prologue();
		emit(enc_i(12'd3, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_r(7'd0, 5'd1, 5'd1, F3_ADD, 5'd2));
		emit(enc_r(7'h20, 5'd1, 5'd2, F3_ADD, 5'd3));
		emit(enc_r(7'd0, 5'd2, 5'd3, F3_XOR, 5'd4));
		emit(enc_i(12'hff0, 5'd4, F3_OR, 5'd5, OPC_OP_IMM));
		emit(enc_i(12'h404, 5'd5, F3_SR, 5'd6, OPC_OP_IMM)); // srai by 4
		emit(enc_r(7'd0, 5'd6, 5'd5, F3_SLT, 5'd7));
		emit(enc_r(7'd0, 5'd6, 5'd5, F3_SLTU, 5'd8));
		emit(enc_r(7'd0, 5'd1, 5'd6, F3_SLL, 5'd9));
		emit(enc_r(7'd0, 5'd1, 5'd6, F3_SR, 5'd10));
		emit(enc_r(7'd0, 5'd9, 5'd10, F3_AND, 5'd11));
		for (int k = 1; k < 12; k++)
			emit(enc_s(12'(k * 4), 5'(k), 5'd0));
		emit(32'h0000_0073);
		run_test(0);

		// load-use on rs1, rs2 and store data
		prologue();
		emit(enc_i(12'd77, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_s(12'd0, 5'd1, 5'd0));
		emit(enc_i(12'd0, 5'd0, F3_WORD, 5'd2, OPC_LOAD));
		emit(enc_i(12'd1, 5'd2, F3_ADD, 5'd3, OPC_OP_IMM));
		emit(enc_i(12'd0, 5'd0, F3_WORD, 5'd4, OPC_LOAD));
		emit(enc_r(7'd0, 5'd4, 5'd3, F3_ADD, 5'd5));
		emit(enc_s(12'd4, 5'd5, 5'd0));
		emit(enc_i(12'd4, 5'd0, F3_WORD, 5'd6, OPC_LOAD));
		emit(enc_s(12'd8, 5'd6, 5'd0));
		emit(enc_s(12'd12, 5'd3, 5'd0));
		emit(32'h0000_0073);
		run_test(0);

		// branches, jal and jalr with skipped stores that must not land
		prologue();
		emit(enc_i(12'd5, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_i(12'd99, 5'd0, F3_ADD, 5'd9, OPC_OP_IMM));
		emit(enc_i(12'd1, 5'd2, F3_ADD, 5'd2, OPC_OP_IMM));
		emit(enc_i(12'hfff, 5'd1, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_b(-13'sd8, 5'd0, 5'd1, F3_BNE));
		emit(enc_s(12'd0, 5'd2, 5'd0));
		emit(enc_i(12'hffd, 5'd0, F3_ADD, 5'd3, OPC_OP_IMM));
		emit(enc_i(12'd2, 5'd0, F3_ADD, 5'd4, OPC_OP_IMM));
		emit(enc_b(13'd8, 5'd4, 5'd3, F3_BLT));
		emit(enc_s(12'd4, 5'd9, 5'd0));
		emit(enc_b(13'd8, 5'd4, 5'd3, F3_BGE));
		emit(enc_s(12'd8, 5'd9, 5'd0));
		emit(enc_b(13'd8, 5'd4, 5'd3, F3_BLTU));
		emit(enc_s(12'd12, 5'd9, 5'd0));
		emit(enc_b(13'd8, 5'd4, 5'd3, F3_BGEU));
		emit(enc_s(12'd16, 5'd9, 5'd0));
		emit(enc_b(13'd8, 5'd3, 5'd3, F3_BEQ));
		emit(enc_s(12'd20, 5'd9, 5'd0));
		emit(enc_j(21'd8, 5'd5));
		emit(enc_s(12'd24, 5'd9, 5'd0));
		emit(enc_s(12'd28, 5'd5, 5'd0));
		emit({20'd0, 5'd6, OPC_AUIPC});
		emit(enc_i(12'd12, 5'd6, 3'd0, 5'd7, OPC_JALR));
		emit(enc_s(12'd32, 5'd9, 5'd0));
		emit(enc_s(12'd36, 5'd7, 5'd0));
		emit(32'h0000_0073);
		run_test(0);

		for (int n = 0; n < 30; n++) begin
			random_prog();
			run_test(0);
		end

		// x0 is never written and a store of x0 stores zero
		prologue();
		emit(enc_i(12'd5, 5'd0, F3_ADD, 5'd0, OPC_OP_IMM));
		emit(enc_i(12'd7, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_s(12'd0, 5'd1, 5'd0));
		emit(enc_i(12'd0, 5'd0, F3_WORD, 5'd0, OPC_LOAD));
		emit(enc_r(7'd0, 5'd0, 5'd0, F3_ADD, 5'd2));
		emit(enc_s(12'd4, 5'd2, 5'd0));
		emit(enc_s(12'd0, 5'd0, 5'd0));
		emit(32'h0000_0073);
		run_test(0);

		// quit an endless loop, then restart elsewhere
		emit(enc_j(21'd0, 5'd0));
		load_prog(0);
		prog.delete();
		budget += 2 * 4 + 50;
		start_core(0, ok);
		repeat (30) @(posedge clk);
		i_quit_cmd <= 1'b1;
		@(posedge clk) i_quit_cmd <= 1'b0;
		repeat (3) @(negedge clk);
		if (o_cpu_run_state) begin
			$display("quit command did not stop the core at %0t", $time);
			errors++;
		end
		prologue();
		emit(enc_i(12'd21, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(enc_r(7'd0, 5'd1, 5'd1, F3_ADD, 5'd2));
		emit(enc_s(12'd8, 5'd2, 5'd0));
		emit(32'h0000_0073);
		run_test(200);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_cpu_top -f all.f -o sim_cpu; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_cpu > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

//--- src/cpu_pkg.sv
/*
 * core micro-architecture definitions
 * ram sizes, alu operations, run states and forwarding selects
 */
package cpu_pkg;

	localparam int IRAM_AW = 10; // word address
	localparam int DRAM_AW = 10;

	typedef logic [31:2] pc_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} run_state_e;

	// operand source for ex
	localparam logic [1:0] FWD_RF = 2'd0;
	localparam logic [1:0] FWD_MA = 2'd1;
	localparam logic [1:0] FWD_WB = 2'd2;

endpackage

//--- src/cpu_status.sv
/*
 * run control of the core
 * idle/run state, start address latch, halt and quit
 */
module cpu_status import cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_cpu_start,
	input logic i_quit_cmd,
	input pc_t i_start_adr,
	input logic i_halt,
	output logic o_cpu_run_state,
	output logic o_pc_start,
	output pc_t o_start_adr_lat,
	output logic o_rst_pipe
);
	run_state_e state;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_pc_start <= 1'b0;
		end else begin
			o_pc_start <= 1'b0;
			case (state)
				ST_IDLE: if (i_cpu_start) begin
					state <= ST_RUN;
					o_pc_start <= 1'b1; // first fetch cycle
				end
				default: if (i_halt || i_quit_cmd)
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_cpu_start)
			o_start_adr_lat <= i_start_adr;
	end

	assign o_cpu_run_state = (state == ST_RUN);
	assign o_rst_pipe = (state == ST_IDLE); // pipe held empty while idle

endmodule

//--- src/cpu_top.sv
/*
 * rv32i five-stage core, top level
 */
module cpu_top import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_cpu_start,
	input logic i_quit_cmd,
	input pc_t i_start_adr,
	input logic i_iram_we,
	input logic [IRAM_AW-1:0] i_iram_wadr,
	input logic [XLEN-1:0] i_iram_wdata,
	input logic [DRAM_AW-1:0] i_dram_radr,
	output logic o_cpu_run_state,
	output logic [XLEN-1:0] o_dram_rdata,
	output logic [XLEN-1:0] o_pc_data
);
	logic pc_start, rst_pipe, halt, stall, jmp, valid_id;
	pc_t start_adr_lat, pc_id, jmp_adr;
	logic [XLEN-1:0] inst_id, ma_result, wb_data;
	logic [REG_AW-1:0] rs1_adr, rs2_adr, wb_rd;
	logic rs1_used, rs2_used, wb_we;
	logic [1:0] fwd_rs1, fwd_rs2;

	dec_if dec ();
	exe_if exe ();

	cpu_status cpu_status (.clk(clk), .i_arst_n(i_arst_n), .i_cpu_start(i_cpu_start),
		.i_quit_cmd(i_quit_cmd), .i_start_adr(i_start_adr), .i_halt(halt),
		.o_cpu_run_state(o_cpu_run_state), .o_pc_start(pc_start),
		.o_start_adr_lat(start_adr_lat), .o_rst_pipe(rst_pipe));

	if_stage if_stage (.clk(clk), .i_arst_n(i_arst_n), .i_pc_start(pc_start),
		.i_start_adr_lat(start_adr_lat), .i_rst_pipe(rst_pipe), .i_stall(stall),
		.i_jmp(jmp), .i_jmp_adr(jmp_adr), .i_iram_we(i_iram_we),
		.i_iram_wadr(i_iram_wadr), .i_iram_wdata(i_iram_wdata),
		.o_inst_id(inst_id), .o_pc_id(pc_id), .o_valid_id(valid_id));

	id_stage id_stage (.clk(clk), .i_arst_n(i_arst_n), .i_inst_id(inst_id), .i_pc_id(pc_id),
		.i_valid_id(valid_id), .i_stall(stall), .i_flush(jmp), .i_rst_pipe(rst_pipe),
		.i_wb_we(wb_we), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
		.o_rs1_adr(rs1_adr), .o_rs2_adr(rs2_adr), .o_rs1_used(rs1_used),
		.o_rs2_used(rs2_used), .dec(dec.source));

	ex_stage ex_stage (.clk(clk), .i_arst_n(i_arst_n), .i_rst_pipe(rst_pipe),
		.dec(dec.sink), .i_fwd_rs1(fwd_rs1), .i_fwd_rs2(fwd_rs2),
		.i_ma_result(ma_result), .i_wb_data(wb_data), .exe(exe.source),
		.o_jmp(jmp), .o_jmp_adr(jmp_adr), .o_pc_data(o_pc_data));

	ma_stage ma_stage (.clk(clk), .i_arst_n(i_arst_n), .i_rst_pipe(rst_pipe),
		.exe(exe.sink), .i_dram_radr(i_dram_radr), .o_dram_rdata(o_dram_rdata),
		.o_ma_result(ma_result), .o_wb_we(wb_we), .o_wb_rd(wb_rd),
		.o_wb_data(wb_data), .o_halt(halt));

	forwarding forwarding (.clk(clk), .i_arst_n(i_arst_n),
		.i_rs1_adr(rs1_adr), .i_rs2_adr(rs2_adr),
		.i_rs1_used(rs1_used), .i_rs2_used(rs2_used),
		.i_ex_rd(dec.rd), .i_ex_we(dec.rf_we), .i_ex_ld(dec.load),
		.i_ma_rd(exe.rd), .i_ma_we(exe.rf_we),
		.o_fwd_rs1(fwd_rs1), .o_fwd_rs2(fwd_rs2), .o_stall(stall));

endmodule

//--- src/ex_stage.sv
/*
 * execute stage
 * operand forwarding, alu, branch compare and jump target
 */
module ex_stage import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_rst_pipe,
	dec_if.sink dec,
	input logic [1:0] i_fwd_rs1,
	input logic [1:0] i_fwd_rs2,
	input logic [XLEN-1:0] i_ma_result,
	input logic [XLEN-1:0] i_wb_data,
	exe_if.source exe,
	output logic o_jmp,
	output pc_t o_jmp_adr,
	output logic [XLEN-1:0] o_pc_data
);
	logic [XLEN-1:0] rs1, rs2, op_a, op_b, alu_y, jmp_tgt, pc_byte;
	logic br_cond;

	function automatic logic [XLEN-1:0] fwd_mux(input logic [1:0] sel,
		input logic [XLEN-1:0] rf_val);
		case (sel)
			FWD_MA: return i_ma_result;
			FWD_WB: return i_wb_data;
			default: return rf_val;
		endcase
	endfunction

	assign rs1 = fwd_mux(i_fwd_rs1, dec.rs1_data);
	assign rs2 = fwd_mux(i_fwd_rs2, dec.rs2_data);
	assign pc_byte = {dec.pc, 2'b00};
	assign o_pc_data = pc_byte;

	assign op_a = dec.pc_a ? pc_byte : dec.lui ? '0 : rs1;
	assign op_b = dec.use_imm ? dec.imm : rs2;

	always_comb begin
		case (dec.alu_op)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_SLL: alu_y = op_a << op_b[4:0];
			ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_y = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR: alu_y = op_a ^ op_b;
			ALU_SRL: alu_y = op_a >> op_b[4:0];
			ALU_SRA: alu_y = $signed(op_a) >>> op_b[4:0];
			ALU_OR: alu_y = op_a | op_b;
			ALU_AND: alu_y = op_a & op_b;
			default: alu_y = op_a + op_b;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			F3_BEQ: br_cond = (rs1 == rs2);
			F3_BNE: br_cond = (rs1 != rs2);
			F3_BLT: br_cond = $signed(rs1) < $signed(rs2);
			F3_BGE: br_cond = $signed(rs1) >= $signed(rs2);
			F3_BLTU: br_cond = rs1 < rs2;
			F3_BGEU: br_cond = rs1 >= rs2;
			default: br_cond = 1'b0;
		endcase
	end

	assign jmp_tgt = (dec.jalr ? rs1 : pc_byte) + dec.imm;
	assign o_jmp_adr = jmp_tgt[31:2];
	assign o_jmp = dec.valid & (dec.jal | dec.jalr | (dec.branch & br_cond));

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			{exe.valid, exe.rf_we, exe.load, exe.store, exe.ecall} <= '0;
		end else begin
			exe.valid <= dec.valid & ~i_rst_pipe;
			exe.rf_we <= dec.rf_we & ~i_rst_pipe;
			exe.load <= dec.load & ~i_rst_pipe;
			exe.store <= dec.store & ~i_rst_pipe;
			exe.ecall <= dec.ecall & ~i_rst_pipe;
		end
	end

	always_ff @(posedge clk) begin
		exe.result <= (dec.jal | dec.jalr) ? pc_byte + 4 : alu_y; // link address
		exe.store_data <= rs2;
		exe.rd <= dec.rd;
	end

endmodule

//--- src/forwarding.sv
/*
 * hazard unit
 * operand source selects for ex and the load-use stall
 */
module forwarding import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic [REG_AW-1:0] i_rs1_adr,
	input logic [REG_AW-1:0] i_rs2_adr,
	input logic i_rs1_used,
	input logic i_rs2_used,
	input logic [REG_AW-1:0] i_ex_rd,
	input logic i_ex_we,
	input logic i_ex_ld,
	input logic [REG_AW-1:0] i_ma_rd,
	input logic i_ma_we,
	output logic [1:0] o_fwd_rs1,
	output logic [1:0] o_fwd_rs2,
	output logic o_stall
);
	logic ld_hit1, ld_hit2;

	// ex now is ma next cycle, ma now is write-back next cycle
	function automatic logic [1:0] fwd_sel(input logic used, input logic [REG_AW-1:0] adr);
		if (!used || adr == '0)
			return FWD_RF;
		else if (i_ex_we && i_ex_rd == adr)
			return FWD_MA;
		else if (i_ma_we && i_ma_rd == adr)
			return FWD_WB;
		else
			return FWD_RF;
	endfunction

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_fwd_rs1 <= FWD_RF;
			o_fwd_rs2 <= FWD_RF;
		end else begin
			o_fwd_rs1 <= fwd_sel(i_rs1_used, i_rs1_adr);
			o_fwd_rs2 <= fwd_sel(i_rs2_used, i_rs2_adr);
		end
	end

	assign ld_hit1 = i_rs1_used && i_rs1_adr == i_ex_rd;
	assign ld_hit2 = i_rs2_used && i_rs2_adr == i_ex_rd;
	assign o_stall = i_ex_ld && i_ex_we && i_ex_rd != '0 && (ld_hit1 || ld_hit2);

endmodule

//--- src/id_stage.sv
/*
 * decode stage
 * instruction decode, immediate generation and register file
 */
module id_stage import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic [XLEN-1:0] i_inst_id,
	input pc_t i_pc_id,
	input logic i_valid_id,
	input logic i_stall,
	input logic i_flush,
	input logic i_rst_pipe,
	input logic i_wb_we,
	input logic [REG_AW-1:0] i_wb_rd,
	input logic [XLEN-1:0] i_wb_data,
	output logic [REG_AW-1:0] o_rs1_adr,
	output logic [REG_AW-1:0] o_rs2_adr,
	output logic o_rs1_used,
	output logic o_rs2_used,
	dec_if.source dec
);
	logic [XLEN-1:0] rf [2**REG_AW];
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [REG_AW-1:0] rd_adr;
	logic [2:0] funct3;
	opcode_e opc;
	alu_op_e d_alu_op;
	logic [XLEN-1:0] d_imm;
	logic d_use_imm, d_pc_a, d_lui, d_rf_we, d_load, d_store;
	logic d_branch, d_jal, d_jalr, d_ecall, rs1_use, rs2_use;
	logic kill;

	function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL: return ALU_SLL;
			F3_SLT: return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR: return ALU_XOR;
			F3_SR: return alt ? ALU_SRA : ALU_SRL;
			F3_OR: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opc = opcode_e'(i_inst_id[6:0]);
	assign funct3 = i_inst_id[F3_LSB +: 3];
	assign rd_adr = i_inst_id[RD_LSB +: REG_AW];
	assign o_rs1_adr = i_inst_id[RS1_LSB +: REG_AW];
	assign o_rs2_adr = i_inst_id[RS2_LSB +: REG_AW];

	assign imm_i = {{20{i_inst_id[31]}}, i_inst_id[31:20]};
	assign imm_s = {{20{i_inst_id[31]}}, i_inst_id[31:25], i_inst_id[11:7]};
	assign imm_b = {{20{i_inst_id[31]}}, i_inst_id[7], i_inst_id[30:25], i_inst_id[11:8], 1'b0};
	assign imm_u = {i_inst_id[31:12], 12'b0};
	assign imm_j = {{12{i_inst_id[31]}}, i_inst_id[19:12], i_inst_id[20], i_inst_id[30:21], 1'b0};

	always_comb begin
		d_alu_op = ALU_ADD;
		d_imm = imm_i;
		{d_use_imm, d_pc_a, d_lui, d_rf_we, d_load, d_store} = '0;
		{d_branch, d_jal, d_jalr, d_ecall, rs1_use, rs2_use} = '0;
		case (opc)
			OPC_OP: begin
				d_alu_op = alu_dec(funct3, i_inst_id[F7_ALT_BIT]);
				{d_rf_we, rs1_use, rs2_use} = 3'b111;
			end
			OPC_OP_IMM: begin
				d_alu_op = alu_dec(funct3, funct3 == F3_SR && i_inst_id[F7_ALT_BIT]);
				{d_use_imm, d_rf_we, rs1_use} = 3'b111;
			end
			OPC_LUI: begin
				d_imm = imm_u;
				{d_use_imm, d_lui, d_rf_we} = 3'b111;
			end
			OPC_AUIPC: begin
				d_imm = imm_u;
				{d_use_imm, d_pc_a, d_rf_we} = 3'b111;
			end
			OPC_LOAD: if (funct3 == F3_WORD) // narrow loads fall through as no-ops
				{d_use_imm, d_load, d_rf_we, rs1_use} = 4'b1111;
			OPC_STORE: if (funct3 == F3_WORD) begin
				d_imm = imm_s;
				{d_use_imm, d_store, rs1_use, rs2_use} = 4'b1111;
			end
			OPC_BRANCH: begin
				d_imm = imm_b;
				{d_branch, rs1_use, rs2_use} = 3'b111;
			end
			OPC_JAL: begin
				d_imm = imm_j;
				{d_jal, d_rf_we} = 2'b11;
			end
			OPC_JALR: {d_jalr, d_rf_we, rs1_use} = 3'b111;
			OPC_SYSTEM: d_ecall = (i_inst_id[31:7] == '0);
			default: ;
		endcase
	end

	assign o_rs1_used = i_valid_id & rs1_use;
	assign o_rs2_used = i_valid_id & rs2_use;

	// x0 reads zero, write-back passes straight through
	assign rs1_data = (o_rs1_adr == '0) ? '0 :
		(i_wb_we && i_wb_rd == o_rs1_adr) ? i_wb_data : rf[o_rs1_adr];
	assign rs2_data = (o_rs2_adr == '0) ? '0 :
		(i_wb_we && i_wb_rd == o_rs2_adr) ? i_wb_data : rf[o_rs2_adr];

	always_ff @(posedge clk) begin
		if (i_wb_we && i_wb_rd != '0)
			rf[i_wb_rd] <= i_wb_data;
	end

	assign kill = i_rst_pipe | i_stall | i_flush | ~i_valid_id; // bubble into ex

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			{dec.valid, dec.rf_we, dec.load, dec.store} <= '0;
			{dec.branch, dec.jal, dec.jalr, dec.ecall} <= '0;
		end else if (kill) begin
			{dec.valid, dec.rf_we, dec.load, dec.store} <= '0;
			{dec.branch, dec.jal, dec.jalr, dec.ecall} <= '0;
		end else begin
			dec.valid <= 1'b1;
			dec.rf_we <= d_rf_we && rd_adr != '0;
			{dec.load, dec.store} <= {d_load, d_store};
			{dec.branch, dec.jal, dec.jalr, dec.ecall} <= {d_branch, d_jal, d_jalr, d_ecall};
		end
	end

	always_ff @(posedge clk) begin
		dec.pc <= i_pc_id;
		dec.alu_op <= d_alu_op;
		{dec.use_imm, dec.pc_a, dec.lui} <= {d_use_imm, d_pc_a, d_lui};
		dec.rs1_data <= rs1_data;
		dec.rs2_data <= rs2_data;
		dec.imm <= d_imm;
		dec.rd <= rd_adr;
		dec.funct3 <= funct3;
	end

endmodule

//--- src/if_stage.sv
/*
 * fetch stage
 * program counter, instruction ram and jump redirect
 */
module if_stage import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_pc_start,
	input pc_t i_start_adr_lat,
	input logic i_rst_pipe,
	input logic i_stall,
	input logic i_jmp,
	input pc_t i_jmp_adr,
	input logic i_iram_we,
	input logic [IRAM_AW-1:0] i_iram_wadr,
	input logic [XLEN-1:0] i_iram_wdata,
	output logic [XLEN-1:0] o_inst_id,
	output pc_t o_pc_id,
	output logic o_valid_id
);
	logic [XLEN-1:0] iram [2**IRAM_AW];
	pc_t pc;
	pc_t fetch_adr;
	logic fetch_en;
	logic fetch_act;

	assign fetch_act = i_pc_start | fetch_en;
	assign fetch_adr = i_pc_start ? i_start_adr_lat : pc;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc <= '0;
			fetch_en <= 1'b0;
			o_valid_id <= 1'b0;
		end else if (i_rst_pipe) begin
			fetch_en <= 1'b0;
			o_valid_id <= 1'b0;
		end else if (i_jmp) begin
			pc <= i_jmp_adr;
			fetch_en <= 1'b1;
			o_valid_id <= 1'b0; // drop the word fetched this cycle
		end else if (!i_stall) begin
			fetch_en <= fetch_act;
			o_valid_id <= fetch_act;
			if (fetch_act)
				pc <= fetch_adr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_iram_we && i_rst_pipe)
			iram[i_iram_wadr] <= i_iram_wdata; // host load, idle only
		if (!i_stall) begin
			o_inst_id <= iram[fetch_adr[IRAM_AW+1:2]];
			o_pc_id <= fetch_adr;
		end
	end

endmodule

//--- src/ma_stage.sv
/*
 * memory access stage with the write-back register
 * data ram, load return and host read port
 */
module ma_stage import rv32i_pkg::*, cpu_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_rst_pipe,
	exe_if.sink exe,
	input logic [DRAM_AW-1:0] i_dram_radr,
	output logic [XLEN-1:0] o_dram_rdata,
	output logic [XLEN-1:0] o_ma_result,
	output logic o_wb_we,
	output logic [REG_AW-1:0] o_wb_rd,
	output logic [XLEN-1:0] o_wb_data,
	output logic o_halt
);
	logic [XLEN-1:0] dram [2**DRAM_AW];
	logic [DRAM_AW-1:0] ma_adr;
	logic [DRAM_AW-1:0] rd_adr;
	logic [XLEN-1:0] ram_q;
	logic [XLEN-1:0] wb_result;
	logic wb_ld;
	logic st_en;

	assign ma_adr = exe.result[DRAM_AW+1:2];
	assign rd_adr = i_rst_pipe ? i_dram_radr : ma_adr; // host side while idle
	assign st_en = exe.valid & exe.store & ~i_rst_pipe;

	always_ff @(posedge clk) begin
		if (st_en)
			dram[ma_adr] <= exe.store_data;
		ram_q <= dram[rd_adr];
		wb_result <= exe.result;
		o_wb_rd <= exe.rd;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_we <= 1'b0;
			wb_ld <= 1'b0;
		end else begin
			o_wb_we <= exe.valid & exe.rf_we & ~i_rst_pipe;
			wb_ld <= exe.load;
		end
	end

	assign o_wb_data = wb_ld ? ram_q : wb_result; // load data lands one cycle later
	assign o_dram_rdata = ram_q;
	assign o_ma_result = exe.result;
	assign o_halt = exe.valid & exe.ecall;

endmodule

//--- src/pipe_if.sv
/*
 * pipeline bundles between decode, execute and memory access
 */
interface dec_if;
	logic valid;
	cpu_pkg::pc_t pc;
	cpu_pkg::alu_op_e alu_op;
	logic use_imm;
	logic pc_a; // pc as operand a
	logic lui;
	logic [rv32i_pkg::XLEN-1:0] rs1_data;
	logic [rv32i_pkg::XLEN-1:0] rs2_data;
	logic [rv32i_pkg::XLEN-1:0] imm;
	logic [rv32i_pkg::REG_AW-1:0] rd;
	logic rf_we;
	logic load;
	logic store;
	logic branch;
	logic [2:0] funct3;
	logic jal;
	logic jalr;
	logic ecall;

	modport source (output valid, pc, alu_op, use_imm, pc_a, lui, rs1_data, rs2_data, imm,
		rd, rf_we, load, store, branch, funct3, jal, jalr, ecall);
	modport sink (input valid, pc, alu_op, use_imm, pc_a, lui, rs1_data, rs2_data, imm,
		rd, rf_we, load, store, branch, funct3, jal, jalr, ecall);
endinterface

interface exe_if;
	logic valid;
	logic [rv32i_pkg::XLEN-1:0] result; // also ld/st address
	logic [rv32i_pkg::XLEN-1:0] store_data;
	logic [rv32i_pkg::REG_AW-1:0] rd;
	logic rf_we;
	logic load;
	logic store;
	logic ecall;

	modport source (output valid, result, store_data, rd, rf_we, load, store, ecall);
	modport sink (input valid, result, store_data, rd, rf_we, load, store, ecall);
endinterface

//--- src/rv32i_pkg.sv
/*
 * rv32i instruction set definitions
 * major opcodes, function codes and field positions
 */
package rv32i_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// instruction field positions
	localparam int RD_LSB = 7;
	localparam int F3_LSB = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_ALT_BIT = 30; // selects sub and sra

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu funct3
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010; // lw and sw

	// branch funct3
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
